//--- hw/csi2_pkt_pkg.sv
`default_nettype none

package csi2_pkt_pkg;

  // Short packet data identifiers
  localparam logic [5:0] DI_FRAME_START  = 6'h00;
  localparam logic [5:0] DI_FRAME_END    = 6'h01;
  localparam logic [5:0] DI_LINE_START   = 6'h02;
  // Data identifiers from here up are long packets
  localparam logic [5:0] LONG_PKT_MIN_DI = 6'h10;

  // Header as it is seen on a long packet
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_count;
    logic [1:0]  vc;
    logic [5:0]  data_id;
  } csi2_long_hdr_t;

  // Header as it is seen on a short packet
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] data_field;
    logic [1:0]  vc;
    logic [5:0]  data_id;
  } csi2_short_hdr_t;

  // The data identifier tells which view applies
  typedef union packed {
    csi2_long_hdr_t  long_v;
    csi2_short_hdr_t short_v;
  } csi2_pkt_hdr_u;

  // One event per received packet header
  typedef struct packed {
    logic          valid;
    csi2_pkt_hdr_u hdr;
    logic          ecc_err;   // header could not be corrected
    logic          ecc_corr;  // single bit error fixed
    logic          crc_err;   // payload CRC mismatch on a long packet
  } csi2_pkt_evt_t;

  // Statistics in status register order
  typedef struct packed {
    logic [31:0] header_err_cnt;
    logic [31:0] corr_header_err_cnt;
    logic [31:0] crc_err_cnt;
    logic [31:0] max_ln_per_frame;
    logic [31:0] min_ln_per_frame;
    logic [31:0] max_px_per_ln;
    logic [31:0] min_px_per_ln;
  } csi2_stat_t;

endpackage

`default_nettype wire

//--- hw/csi2_csr_pkg.sv
`default_nettype none

package csi2_csr_pkg;

  // Bus widths
  localparam int CSR_DATA_WIDTH = 32;
  localparam int CSR_ADDR_WIDTH = 8;
  localparam int CSR_STRB_WIDTH = CSR_DATA_WIDTH / 8;
  // Byte address bits below the word index
  localparam int CSR_ADDR_LSB   = $clog2( CSR_STRB_WIDTH );

  // Control registers
  localparam int CLEAR_STAT_CR      = 0;
  localparam int PHY_ENABLE_CR      = 1;
  localparam int SCCB_SLAVE_ADDR_CR = 2;
  localparam int LANE_0_DELAY_CR    = 3;
  localparam int LANE_1_DELAY_CR    = 4;
  localparam int DELAY_ACT_CR       = 5;
  localparam int CAM_RST_STB_CR     = 6;

  // Status registers, same order as the statistics struct
  localparam int HEADER_ERR_CNT_SR      = 7;
  localparam int CORR_HEADER_ERR_CNT_SR = 8;
  localparam int CRC_ERR_CNT_SR         = 9;
  localparam int MAX_LN_PER_FRAME_SR    = 10;
  localparam int MIN_LN_PER_FRAME_SR    = 11;
  localparam int MAX_PX_PER_LN_SR       = 12;
  localparam int MIN_PX_PER_LN_SR       = 13;

  localparam int TOTAL_CR_CNT   = 7;
  localparam int TOTAL_SR_CNT   = 7;
  localparam int TOTAL_REGS_CNT = TOTAL_CR_CNT + TOTAL_SR_CNT;

  // AXI4-Lite master to slave
  typedef struct packed {
    logic                        awvalid;
    logic [CSR_ADDR_WIDTH - 1:0] awaddr;
    logic                        wvalid;
    logic [CSR_DATA_WIDTH - 1:0] wdata;
    logic [CSR_STRB_WIDTH - 1:0] wstrb;
    logic                        bready;
    logic                        arvalid;
    logic [CSR_ADDR_WIDTH - 1:0] araddr;
    logic                        rready;
  } csi2_axil_req_t;

  // AXI4-Lite slave to master
  typedef struct packed {
    logic                        awready;
    logic                        wready;
    logic                        bvalid;
    logic [1:0]                  bresp;
    logic                        arready;
    logic                        rvalid;
    logic [CSR_DATA_WIDTH - 1:0] rdata;
    logic [1:0]                  rresp;
  } csi2_axil_rsp_t;

  // Controls towards the PHY and camera
  typedef struct packed {
    logic       phy_en;
    logic [6:0] sccb_slave_addr;
    logic [4:0] lane_0_delay;
    logic [4:0] lane_1_delay;
    logic       delay_act;
    logic       cam_rst_stb;
  } csi2_ctrl_t;

endpackage

`default_nettype wire

//--- hw/csi2_stat_acc.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_stat_acc (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  csi2_pkt_pkg::csi2_pkt_evt_t pkt_i,
  input  logic                        clear_i,
  output csi2_pkt_pkg::csi2_stat_t    stat_o
);

// Counters and max start at zero, min at all ones
localparam csi2_pkt_pkg::csi2_stat_t STAT_RST = '{
  header_err_cnt:      32'd0,
  corr_header_err_cnt: 32'd0,
  crc_err_cnt:         32'd0,
  max_ln_per_frame:    32'd0,
  min_ln_per_frame:    32'hffff_ffff,
  max_px_per_ln:       32'd0,
  min_px_per_ln:       32'hffff_ffff
};

csi2_pkt_pkg::csi2_stat_t stat_q;

// Lines seen since the last frame start
logic [31:0] ln_cnt;
logic        frame_open;

logic        hdr_ok;
logic [5:0]  data_id;
logic        is_long;
logic        frame_done;
logic [31:0] wc_ext;

// Uncorrectable headers carry untrusted fields
assign hdr_ok     = pkt_i.valid && !pkt_i.ecc_err;
assign data_id    = pkt_i.hdr.short_v.data_id;
assign is_long    = data_id >= csi2_pkt_pkg::LONG_PKT_MIN_DI;
assign frame_done = hdr_ok && frame_open && ( data_id == csi2_pkt_pkg::DI_FRAME_END );
assign wc_ext     = 32'( pkt_i.hdr.long_v.word_count );

// Frame tracking from short packets
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      ln_cnt     <= '0;
      frame_open <= 1'b0;
    end
  else
    if( hdr_ok )
      case( data_id )
        csi2_pkt_pkg::DI_FRAME_START:
          begin
            ln_cnt     <= '0;
            frame_open <= 1'b1;
          end
        csi2_pkt_pkg::DI_LINE_START:
          ln_cnt <= ln_cnt + 32'd1;
        csi2_pkt_pkg::DI_FRAME_END:
          frame_open <= 1'b0;
        default:
          ;
      endcase

// Clear has priority over a coincident event
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    stat_q <= STAT_RST;
  else
    if( clear_i )
      stat_q <= STAT_RST;
    else
      if( pkt_i.valid )
        begin
          if( pkt_i.ecc_err )
            stat_q.header_err_cnt <= stat_q.header_err_cnt + 32'd1;
          if( pkt_i.ecc_corr )
            stat_q.corr_header_err_cnt <= stat_q.corr_header_err_cnt + 32'd1;
          // CRC only exists on long packets
          if( pkt_i.crc_err && is_long )
            stat_q.crc_err_cnt <= stat_q.crc_err_cnt + 32'd1;
          if( frame_done )
            begin
              if( ln_cnt > stat_q.max_ln_per_frame )
                stat_q.max_ln_per_frame <= ln_cnt;
              if( ln_cnt < stat_q.min_ln_per_frame )
                stat_q.min_ln_per_frame <= ln_cnt;
            end
          // Word count of a long packet is the line length in bytes
          if( hdr_ok && is_long )
            begin
              if( wc_ext > stat_q.max_px_per_ln )
                stat_q.max_px_per_ln <= wc_ext;
              if( wc_ext < stat_q.min_px_per_ln )
                stat_q.min_px_per_ln <= wc_ext;
            end
        end

assign stat_o = stat_q;

endmodule

`default_nettype wire

//--- hw/csi2_csr.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_csr (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  csi2_csr_pkg::csi2_axil_req_t axil_req_i,
  output csi2_csr_pkg::csi2_axil_rsp_t axil_rsp_o,
  input  csi2_pkt_pkg::csi2_stat_t     stat_i,
  output logic                         clear_stat_o,
  output csi2_csr_pkg::csi2_ctrl_t     ctrl_o
);

localparam int DW       = csi2_csr_pkg::CSR_DATA_WIDTH;
localparam int CR_CNT   = csi2_csr_pkg::TOTAL_CR_CNT;
localparam int SR_CNT   = csi2_csr_pkg::TOTAL_SR_CNT;
localparam int IDX_W    = csi2_csr_pkg::CSR_ADDR_WIDTH - csi2_csr_pkg::CSR_ADDR_LSB;
localparam int CR_IDX_W = $clog2( CR_CNT );
localparam int SR_IDX_W = $clog2( SR_CNT );

logic [CR_CNT - 1:0][DW - 1:0] cr;
logic [SR_CNT - 1:0][DW - 1:0] sr;

logic                wr_en;
logic [IDX_W - 1:0]  wr_idx;
logic [IDX_W - 1:0]  rd_idx;
logic                bvalid_q;
logic                rvalid_q;
logic [DW - 1:0]     rdata_q;

// Strobe order is clear, delay act, camera reset
logic [2:0] stb_lvl;
logic [2:0] stb_d1;
logic [2:0] stb;

// Address and data are expected in the same cycle
assign wr_en  = axil_req_i.awvalid && axil_req_i.wvalid;
assign wr_idx = axil_req_i.awaddr[csi2_csr_pkg::CSR_ADDR_WIDTH - 1:csi2_csr_pkg::CSR_ADDR_LSB];
assign rd_idx = axil_req_i.araddr[csi2_csr_pkg::CSR_ADDR_WIDTH - 1:csi2_csr_pkg::CSR_ADDR_LSB];

// Responses one cycle after the request
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
  else
    begin
      bvalid_q <= wr_en;
      rvalid_q <= axil_req_i.arvalid;
    end

// Only control words are writable, byte by byte
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    cr <= '0;
  else
    if( wr_en )
      for( int i = 0; i < CR_CNT; i++ )
        if( wr_idx == IDX_W'( i ) )
          for( int j = 0; j < csi2_csr_pkg::CSR_STRB_WIDTH; j++ )
            if( axil_req_i.wstrb[j] )
              cr[i][j * 8 + 7 -: 8] <= axil_req_i.wdata[j * 8 + 7 -: 8];

// Control, then status, then zero for unmapped words
always_ff @( posedge clk_i )
  if( axil_req_i.arvalid )
    begin
      if( rd_idx < IDX_W'( CR_CNT ) )
        rdata_q <= cr[CR_IDX_W'( rd_idx )];
      else if( rd_idx < IDX_W'( csi2_csr_pkg::TOTAL_REGS_CNT ) )
        rdata_q <= sr[SR_IDX_W'( rd_idx - IDX_W'( CR_CNT ) )];
      else
        rdata_q <= '0;
    end

assign sr[csi2_csr_pkg::HEADER_ERR_CNT_SR - CR_CNT]      = stat_i.header_err_cnt;
assign sr[csi2_csr_pkg::CORR_HEADER_ERR_CNT_SR - CR_CNT] = stat_i.corr_header_err_cnt;
assign sr[csi2_csr_pkg::CRC_ERR_CNT_SR - CR_CNT]         = stat_i.crc_err_cnt;
assign sr[csi2_csr_pkg::MAX_LN_PER_FRAME_SR - CR_CNT]    = stat_i.max_ln_per_frame;
assign sr[csi2_csr_pkg::MIN_LN_PER_FRAME_SR - CR_CNT]    = stat_i.min_ln_per_frame;
assign sr[csi2_csr_pkg::MAX_PX_PER_LN_SR - CR_CNT]       = stat_i.max_px_per_ln;
assign sr[csi2_csr_pkg::MIN_PX_PER_LN_SR - CR_CNT]       = stat_i.min_px_per_ln;

// Rising edge of bit 0 gives a one-cycle strobe
assign stb_lvl = { cr[csi2_csr_pkg::CAM_RST_STB_CR][0],
                   cr[csi2_csr_pkg::DELAY_ACT_CR][0],
                   cr[csi2_csr_pkg::CLEAR_STAT_CR][0] };

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    stb_d1 <= '0;
  else
    stb_d1 <= stb_lvl;

assign stb          = stb_lvl & ~stb_d1;
assign clear_stat_o = stb[0];

always_comb
  begin
    ctrl_o.phy_en          = cr[csi2_csr_pkg::PHY_ENABLE_CR][0];
    ctrl_o.sccb_slave_addr = cr[csi2_csr_pkg::SCCB_SLAVE_ADDR_CR][6:0];
    ctrl_o.lane_0_delay    = cr[csi2_csr_pkg::LANE_0_DELAY_CR][4:0];
    ctrl_o.lane_1_delay    = cr[csi2_csr_pkg::LANE_1_DELAY_CR][4:0];
    ctrl_o.delay_act       = stb[1];
    ctrl_o.cam_rst_stb     = stb[2];
  end

// Always ready, always OKAY
always_comb
  begin
    axil_rsp_o.awready = 1'b1;
    axil_rsp_o.wready  = 1'b1;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.arready = 1'b1;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = 2'b00;
  end

endmodule

`default_nettype wire

//--- hw/csi2_rx_stat_top.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_rx_stat_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  csi2_csr_pkg::csi2_axil_req_t axil_req_i,
  output csi2_csr_pkg::csi2_axil_rsp_t axil_rsp_o,
  input  csi2_pkt_pkg::csi2_pkt_evt_t  pkt_i,
  output csi2_csr_pkg::csi2_ctrl_t     ctrl_o
);

// Statistics towards the register slave
csi2_pkt_pkg::csi2_stat_t stat;
// One-cycle clear request back to the accumulator
logic                     clear_stat;

csi2_stat_acc u_stat_acc (
  .clk_i   ( clk_i      ),
  .rst_i   ( rst_i      ),
  .pkt_i   ( pkt_i      ),
  .clear_i ( clear_stat ),
  .stat_o  ( stat       )
);

// Register slave also drives the PHY controls
csi2_csr u_csr (
  .clk_i        ( clk_i      ),
  .rst_i        ( rst_i      ),
  .axil_req_i   ( axil_req_i ),
  .axil_rsp_o   ( axil_rsp_o ),
  .stat_i       ( stat       ),
  .clear_stat_o ( clear_stat ),
  .ctrl_o       ( ctrl_o     )
);

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    // Hold reset over two rising edges, release just after the second
    repeat( 2 ) @( posedge clk_o );
    #10;
    rst_o = 1'b0;
  end

// 100 ns period
always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- verif/csi2_csr_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_csr_asserts (
  input logic                         clk_i,
  input logic                         rst_i,
  input csi2_csr_pkg::csi2_axil_req_t req_i,
  input csi2_csr_pkg::csi2_axil_rsp_t rsp_i,
  input logic                         clear_stat_i,
  input csi2_csr_pkg::csi2_ctrl_t     ctrl_i
);

// Write response exactly one cycle after the write
bvalid_after_write: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rsp_i.bvalid == $past( req_i.awvalid && req_i.wvalid ) )
  else $error( "bvalid does not follow the write by one cycle" );

// Read response exactly one cycle after arvalid
rvalid_after_read: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rsp_i.rvalid == $past( req_i.arvalid ) )
  else $error( "rvalid does not follow arvalid by one cycle" );

// Strobes last a single cycle
clear_one_cycle: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  clear_stat_i |=> !clear_stat_i )
  else $error( "clear strobe longer than one cycle" );

delay_act_one_cycle: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  ctrl_i.delay_act |=> !ctrl_i.delay_act )
  else $error( "delay_act strobe longer than one cycle" );

cam_rst_one_cycle: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  ctrl_i.cam_rst_stb |=> !ctrl_i.cam_rst_stb )
  else $error( "cam_rst_stb strobe longer than one cycle" );

endmodule

bind csi2_csr csi2_csr_asserts u_csr_asserts (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .req_i        ( axil_req_i   ),
  .rsp_i        ( axil_rsp_o   ),
  .clear_stat_i ( clear_stat_o ),
  .ctrl_i       ( ctrl_o       )
);

`default_nettype wire

//--- verif/tb_csi2_rx_stat.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csi2_rx_stat;

// Rough length of each test in clock cycles
localparam int RESET_MAP_CYC = 40;
localparam int CTRL_CYC      = 70;
localparam int STROBE_CYC    = 60;
localparam int ERR_CYC       = 240;
localparam int GEOM_CYC      = 440;
localparam int CLEAR_CYC     = 120;
localparam int TIMEOUT_CYC   = 2 * ( RESET_MAP_CYC + CTRL_CYC + STROBE_CYC + ERR_CYC
                                     + GEOM_CYC + CLEAR_CYC );

logic                         clk_i;
logic                         rst_i;
csi2_csr_pkg::csi2_axil_req_t axil_req;
csi2_csr_pkg::csi2_axil_rsp_t axil_rsp;
csi2_pkt_pkg::csi2_pkt_evt_t  pkt;
csi2_csr_pkg::csi2_ctrl_t     ctrl;

// Model state
csi2_pkt_pkg::csi2_stat_t m_stat;
logic [31:0]              m_lines;
logic                     m_in_frame;
logic [31:0]              cr_m [csi2_csr_pkg::TOTAL_CR_CNT];

logic [31:0] lfsr_q;
int          errors;
int          checks;
int          tests;
int          test_err0;
string       test_name;
int          cycles;

// Pending register reads for the comparing process
string       cmp_name_q [$];
logic [31:0] cmp_exp_q  [$];
logic [31:0] cmp_got_q  [$];

tb_clk_gen u_clk_gen (
  .clk_o ( clk_i ),
  .rst_o ( rst_i )
);

csi2_rx_stat_top u_dut (
  .clk_i      ( clk_i    ),
  .rst_i      ( rst_i    ),
  .axil_req_i ( axil_req ),
  .axil_rsp_o ( axil_rsp ),
  .pkt_i      ( pkt      ),
  .ctrl_o     ( ctrl     )
);

function automatic logic [31:0] lfsr_step( input logic [31:0] s );
  if( s[0] )
    return ( s >> 1 ) ^ 32'h8020_0003;
  else
    return s >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits( input int n );
  logic [31:0] v;
  v = '0;
  for( int i = 0; i < n; i++ )
    begin
      v      = { v[30:0], lfsr_q[0] };
      lfsr_q = lfsr_step( lfsr_q );
    end
  return v;
endfunction

function automatic csi2_pkt_pkg::csi2_stat_t stat_reset();
  csi2_pkt_pkg::csi2_stat_t s;
  s                  = '0;
  s.min_ln_per_frame = 32'hffff_ffff;
  s.min_px_per_ln    = 32'hffff_ffff;
  return s;
endfunction

function automatic logic [31:0] stat_word( input csi2_pkt_pkg::csi2_stat_t s, input int idx );
  case( idx )
    csi2_csr_pkg::HEADER_ERR_CNT_SR:      return s.header_err_cnt;
    csi2_csr_pkg::CORR_HEADER_ERR_CNT_SR: return s.corr_header_err_cnt;
    csi2_csr_pkg::CRC_ERR_CNT_SR:         return s.crc_err_cnt;
    csi2_csr_pkg::MAX_LN_PER_FRAME_SR:    return s.max_ln_per_frame;
    csi2_csr_pkg::MIN_LN_PER_FRAME_SR:    return s.min_ln_per_frame;
    csi2_csr_pkg::MAX_PX_PER_LN_SR:       return s.max_px_per_ln;
    csi2_csr_pkg::MIN_PX_PER_LN_SR:       return s.min_px_per_ln;
    default:                              return '0;
  endcase
endfunction

// Reference model of the statistics rules, one event at a time
function automatic csi2_pkt_pkg::csi2_stat_t model_event( input csi2_pkt_pkg::csi2_stat_t m,
                                                          input csi2_pkt_pkg::csi2_pkt_evt_t e );
  csi2_pkt_pkg::csi2_stat_t r;
  logic [5:0]               di;
  logic [31:0]              wc;
  r  = m;
  di = e.hdr.short_v.data_id;
  wc = { 16'h0000, e.hdr.long_v.word_count };
  if( e.valid )
    begin
      if( e.ecc_err )
        r.header_err_cnt = r.header_err_cnt + 32'd1;
      if( e.ecc_corr )
        r.corr_header_err_cnt = r.corr_header_err_cnt + 32'd1;
      if( e.crc_err && di >= csi2_pkt_pkg::LONG_PKT_MIN_DI )
        r.crc_err_cnt = r.crc_err_cnt + 32'd1;
      if( !e.ecc_err )
        begin
          if( di == csi2_pkt_pkg::DI_FRAME_START )
            begin
              m_lines    = '0;
              m_in_frame = 1'b1;
            end
          else if( di == csi2_pkt_pkg::DI_LINE_START )
            m_lines = m_lines + 32'd1;
          else if( di == csi2_pkt_pkg::DI_FRAME_END )
            begin
              if( m_in_frame )
                begin
                  if( m_lines > r.max_ln_per_frame )
                    r.max_ln_per_frame = m_lines;
                  if( m_lines < r.min_ln_per_frame )
                    r.min_ln_per_frame = m_lines;
                end
              m_in_frame = 1'b0;
            end
          else if( di >= csi2_pkt_pkg::LONG_PKT_MIN_DI )
            begin
              if( wc > r.max_px_per_ln )
                r.max_px_per_ln = wc;
              if( wc < r.min_px_per_ln )
                r.min_px_per_ln = wc;
            end
        end
    end
  return r;
endfunction

function automatic csi2_pkt_pkg::csi2_pkt_evt_t make_event( input logic [5:0]  di,
                                                            input logic [15:0] wc,
                                                            input logic        ecc_err,
                                                            input logic        ecc_corr,
                                                            input logic        crc_err );
  csi2_pkt_pkg::csi2_pkt_evt_t e;
  e                        = '0;
  e.valid                  = 1'b1;
  e.hdr.long_v.data_id     = di;
  e.hdr.long_v.vc          = 2'( rand_bits( 2 ) );
  e.hdr.long_v.word_count  = wc;
  e.hdr.long_v.ecc         = 8'( rand_bits( 8 ) );
  e.ecc_err                = ecc_err;
  e.ecc_corr               = ecc_corr;
  e.crc_err                = crc_err;
  return e;
endfunction

task automatic check_word( input string name,
                           input logic [csi2_csr_pkg::CSR_DATA_WIDTH - 1:0] exp,
                           input logic [csi2_csr_pkg::CSR_DATA_WIDTH - 1:0] got );
  checks++;
  if( exp !== got )
    begin
      errors++;
      $display( "FAILED at %0t: %s expected %h got %h", $time, name, exp, got );
    end
endtask

task automatic check_ctrl( input csi2_csr_pkg::csi2_ctrl_t exp,
                           input csi2_csr_pkg::csi2_ctrl_t got );
  checks++;
  if( exp !== got )
    begin
      errors++;
      $display( "FAILED at %0t: ctrl_o expected %h got %h", $time, exp, got );
    end
endtask

task automatic check_bit( input string name, input logic exp, input logic got );
  checks++;
  if( exp !== got )
    begin
      errors++;
      $display( "FAILED at %0t: %s expected %b got %b", $time, name, exp, got );
    end
endtask

task automatic report_error( input string what );
  errors++;
  $display( "FAILED at %0t: %s", $time, what );
endtask

// Comparing process for register reads
always @( posedge clk_i )
  while( cmp_got_q.size() > 0 )
    check_word( cmp_name_q.pop_front(), cmp_exp_q.pop_front(), cmp_got_q.pop_front() );

always @( posedge clk_i )
  begin
    cycles++;
    if( cycles >= TIMEOUT_CYC )
      begin
        $display( "Run stopped after %0d cycles without finishing", cycles );
        $display( "Testbench failed" );
        $finish;
      end
  end

task automatic write_word( input int idx, input logic [31:0] data, input logic [3:0] strb );
  @( posedge clk_i );
  #10;
  axil_req.awvalid = 1'b1;
  axil_req.awaddr  = 8'( idx << 2 );
  axil_req.wvalid  = 1'b1;
  axil_req.wdata   = data;
  axil_req.wstrb   = strb;
  check_bit( "axil_rsp_o.awready", 1'b1, axil_rsp.awready );
  check_bit( "axil_rsp_o.wready", 1'b1, axil_rsp.wready );
  if( idx < csi2_csr_pkg::TOTAL_CR_CNT )
    for( int j = 0; j < 4; j++ )
      if( strb[j] )
        cr_m[idx][j * 8 +: 8] = data[j * 8 +: 8];
  @( posedge clk_i );
  #10;
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b0;
  if( !axil_rsp.bvalid )
    report_error( "no write response in the cycle after the write" );
  check_word( "axil_rsp_o.bresp", 32'h0, 32'( axil_rsp.bresp ) );
endtask

task automatic read_word( input int idx, output logic [31:0] data );
  @( posedge clk_i );
  #10;
  axil_req.arvalid = 1'b1;
  axil_req.araddr  = 8'( idx << 2 );
  check_bit( "axil_rsp_o.arready", 1'b1, axil_rsp.arready );
  @( posedge clk_i );
  #10;
  axil_req.arvalid = 1'b0;
  data             = axil_rsp.rdata;
  if( !axil_rsp.rvalid )
    report_error( "no read response in the cycle after arvalid" );
  check_word( "axil_rsp_o.rresp", 32'h0, 32'( axil_rsp.rresp ) );
endtask

task automatic expect_word( input int idx, input logic [31:0] exp );
  logic [31:0] got;
  read_word( idx, got );
  cmp_name_q.push_back( $sformatf( "reg[%0d]", idx ) );
  cmp_exp_q.push_back( exp );
  cmp_got_q.push_back( got );
endtask

task automatic expect_stats();
  for( int i = csi2_csr_pkg::HEADER_ERR_CNT_SR; i < csi2_csr_pkg::TOTAL_REGS_CNT; i++ )
    expect_word( i, stat_word( m_stat, i ) );
endtask

task automatic send_event( input csi2_pkt_pkg::csi2_pkt_evt_t e );
  @( posedge clk_i );
  #10;
  pkt    = e;
  m_stat = model_event( m_stat, e );
endtask

task automatic stop_events();
  @( posedge clk_i );
  #10;
  pkt = '0;
endtask

function automatic csi2_csr_pkg::csi2_ctrl_t expected_ctrl( input logic delay_act,
                                                            input logic cam_rst_stb );
  csi2_csr_pkg::csi2_ctrl_t c;
  c.phy_en          = cr_m[csi2_csr_pkg::PHY_ENABLE_CR][0];
  c.sccb_slave_addr = cr_m[csi2_csr_pkg::SCCB_SLAVE_ADDR_CR][6:0];
  c.lane_0_delay    = cr_m[csi2_csr_pkg::LANE_0_DELAY_CR][4:0];
  c.lane_1_delay    = cr_m[csi2_csr_pkg::LANE_1_DELAY_CR][4:0];
  c.delay_act       = delay_act;
  c.cam_rst_stb     = cam_rst_stb;
  return c;
endfunction

task automatic start_test( input string name );
  test_name = name;
  test_err0 = errors;
endtask

task automatic end_test();
  // Let the comparing process drain pending reads
  @( posedge clk_i );
  #1;
  tests++;
  $display( "test %s: %0d errors", test_name, errors - test_err0 );
endtask

// Write 1 to a strobe register and watch the pulse
task automatic strobe_pulse( input int idx, input string name, input logic expect_rise );
  write_word( idx, 32'h0000_0001, 4'hf );
  if( idx == csi2_csr_pkg::DELAY_ACT_CR )
    check_bit( name, expect_rise, ctrl.delay_act );
  else
    check_bit( name, expect_rise, ctrl.cam_rst_stb );
  for( int k = 0; k < 3; k++ )
    begin
      @( posedge clk_i );
      #10;
      if( idx == csi2_csr_pkg::DELAY_ACT_CR )
        check_bit( name, 1'b0, ctrl.delay_act );
      else
        check_bit( name, 1'b0, ctrl.cam_rst_stb );
    end
endtask

task automatic strobe_test( input int idx, input string name );
  write_word( idx, 32'h0000_0000, 4'hf );
  strobe_pulse( idx, name, 1'b1 );
  strobe_pulse( idx, name, 1'b0 );
  write_word( idx, 32'h0000_0000, 4'hf );
  strobe_pulse( idx, name, 1'b1 );
endtask

initial
  begin
    logic                        rise;
    logic                        prev;
    logic [3:0]                  strb;
    int                          lines;
    csi2_pkt_pkg::csi2_pkt_evt_t e;

    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    pkt             = '0;
    lfsr_q          = 32'h24ab_fce3;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    cycles          = 0;
    m_stat          = stat_reset();
    m_lines         = '0;
    m_in_frame      = 1'b0;
    for( int i = 0; i < csi2_csr_pkg::TOTAL_CR_CNT; i++ )
      cr_m[i] = '0;

    @( negedge rst_i );

    start_test( "reset_map" );
    check_ctrl( '0, ctrl );
    check_bit( "axil_rsp_o.bvalid", 1'b0, axil_rsp.bvalid );
    check_bit( "axil_rsp_o.rvalid", 1'b0, axil_rsp.rvalid );
    for( int i = 0; i < csi2_csr_pkg::TOTAL_CR_CNT; i++ )
      expect_word( i, 32'h0 );
    expect_stats();
    expect_word( csi2_csr_pkg::TOTAL_REGS_CNT, 32'h0 );
    expect_word( 63, 32'h0 );
    end_test();

    start_test( "control_writes" );
    for( int i = 0; i < csi2_csr_pkg::TOTAL_CR_CNT; i++ )
      begin
        write_word( i, rand_bits( 32 ), 4'hf );
        write_word( i, 32'h0, 4'hf );
        prev = cr_m[i][0];
        strb = 4'( rand_bits( 4 ) );
        write_word( i, rand_bits( 32 ), strb );
        rise = !prev && cr_m[i][0];
        check_ctrl( expected_ctrl( rise && i == csi2_csr_pkg::DELAY_ACT_CR,
                                   rise && i == csi2_csr_pkg::CAM_RST_STB_CR ), ctrl );
        expect_word( i, cr_m[i] );
      end
    write_word( csi2_csr_pkg::CRC_ERR_CNT_SR, 32'hffff_ffff, 4'hf );
    expect_word( csi2_csr_pkg::CRC_ERR_CNT_SR, stat_word( m_stat, csi2_csr_pkg::CRC_ERR_CNT_SR ) );
    write_word( csi2_csr_pkg::CLEAR_STAT_CR, 32'h0, 4'hf );
    write_word( csi2_csr_pkg::DELAY_ACT_CR, 32'h0, 4'hf );
    write_word( csi2_csr_pkg::CAM_RST_STB_CR, 32'h0, 4'hf );
    check_ctrl( expected_ctrl( 1'b0, 1'b0 ), ctrl );
    end_test();

    start_test( "strobes" );
    strobe_test( csi2_csr_pkg::DELAY_ACT_CR, "ctrl_o.delay_act" );
    strobe_test( csi2_csr_pkg::CAM_RST_STB_CR, "ctrl_o.cam_rst_stb" );
    end_test();

    start_test( "error_counts" );
    for( int n = 0; n < 200; n++ )
      begin
        e = make_event( 6'( rand_bits( 6 ) ), 16'( rand_bits( 16 ) ), rand_bits( 1 ) == 32'd1,
                        rand_bits( 1 ) == 32'd1, rand_bits( 1 ) == 32'd1 );
        send_event( e );
      end
    stop_events();
    expect_stats();
    end_test();

    start_test( "geometry" );
    for( int f = 0; f < 8; f++ )
      begin
        lines = 1 + int'( rand_bits( 4 ) );
        // Frame 2 loses its frame start, frame 5 its frame end
        send_event( make_event( csi2_pkt_pkg::DI_FRAME_START, 16'( f ), f == 2, 1'b0, 1'b0 ) );
        for( int l = 0; l < lines; l++ )
          begin
            send_event( make_event( csi2_pkt_pkg::DI_LINE_START, 16'( l ), 1'b0, 1'b0, 1'b0 ) );
            send_event( make_event( csi2_pkt_pkg::LONG_PKT_MIN_DI + 6'( rand_bits( 5 ) ),
                                    16'( rand_bits( 16 ) ), 1'b0, rand_bits( 1 ) == 32'd1,
                                    rand_bits( 1 ) == 32'd1 ) );
            if( l % 4 == 3 )
              send_event( make_event( csi2_pkt_pkg::LONG_PKT_MIN_DI, 16'hffff, 1'b1, 1'b0, 1'b0 ) );
          end
        send_event( make_event( csi2_pkt_pkg::DI_FRAME_END, 16'( f ), f == 5, 1'b0, 1'b0 ) );
      end
    stop_events();
    expect_stats();
    end_test();

    start_test( "clear" );
    write_word( csi2_csr_pkg::CLEAR_STAT_CR, 32'h0000_0001, 4'hf );
    check_bit( "clear_stat", 1'b1, u_dut.clear_stat );
    m_stat = stat_reset();
    expect_stats();
    write_word( csi2_csr_pkg::CLEAR_STAT_CR, 32'h0, 4'hf );
    for( int n = 0; n < 30; n++ )
      begin
        e = make_event( 6'( rand_bits( 6 ) ), 16'( rand_bits( 16 ) ), rand_bits( 1 ) == 32'd1,
                        rand_bits( 1 ) == 32'd1, rand_bits( 1 ) == 32'd1 );
        send_event( e );
      end
    stop_events();
    expect_stats();
    end_test();

    $display( "%0d tests, %0d checks, %0d errors", tests, checks, errors );
    if( errors == 0 )
      $display( "Testbench passed" );
    else
      $display( "Testbench failed" );
    $finish;
  end

endmodule

`default_nettype wire

//--- csi2_rx_stat.f
hw/csi2_pkt_pkg.sv
hw/csi2_csr_pkg.sv
hw/csi2_stat_acc.sv
hw/csi2_csr.sv
hw/csi2_rx_stat_top.sv
verif/tb_clk_gen.sv
verif/csi2_csr_asserts.sv
verif/tb_csi2_rx_stat.sv

//--- Makefile
TOP = tb_csi2_rx_stat

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f csi2_rx_stat.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
